/* serial_link_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial link shared types
// Word and length widths, the transmit request entry, frame type bit
// values and the state encodings of both link ends
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package serial_link_pkg;

    // Default geometry of the link
    localparam int WORD_W = 15;
    localparam int LEN_W  = 4;

    // Payload word, left-aligned
    typedef logic [WORD_W-1:0] word_t;

    // Payload bit count
    typedef logic [LEN_W-1:0] len_t;

    // Queue entry and serializer input
    typedef struct packed {
        logic  is_addr;
        word_t payload;
    } frame_req_t;

    // Type bit sent after the start bit
    localparam logic TYPE_ADDR = 1'b0;
    localparam logic TYPE_DATA = 1'b1;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_START,
        SER_TYPE,
        SER_DATA
    } ser_state_t;

    typedef enum logic [1:0] {
        DES_IDLE,
        DES_TYPE,
        DES_DATA
    } des_state_t;

endpackage

`default_nettype wire

/* tx_queue.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit queue
// Circular buffer of frame requests feeding the serializer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tx_queue
    import serial_link_pkg::*;
#(
    parameter int WIDTH = WORD_W,
    parameter int DEPTH = 4
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       push,
    input  frame_req_t push_req,
    input  logic       pop,
    output frame_req_t head,
    output logic       empty,
    output logic       full
);

    // Type bit plus payload
    localparam int ENTRY_W = WIDTH + 1;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W   = $clog2(DEPTH + 1);

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // A push while full is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = frame_req_t'(mem[rd_ptr]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

endmodule

`default_nettype wire

/* parallel_serial.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame serializer
// Pops one request at a time and sends start bit, type bit and payload
// MSB first, one bit per clock. Line idles high between frames
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module parallel_serial
    import serial_link_pkg::*;
#(
    parameter int WIDTH    = WORD_W,
    parameter int LEN_BITS = LEN_W
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       empty,
    input  frame_req_t head,
    output logic       pop,
    input  len_t       eff_len,
    output logic       line,
    output logic       data_sent
);

    ser_state_t          state;
    logic                is_addr_q;
    logic [LEN_BITS-1:0] bit_cnt;
    logic [WIDTH-1:0]    shift_buf;

    // Take the head entry as soon as we are idle
    assign pop = (state == SER_IDLE) && !empty;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= SER_IDLE;
            is_addr_q <= 1'b0;
            bit_cnt   <= '0;
            line      <= 1'b1;
            data_sent <= 1'b0;
        end else begin
            data_sent <= 1'b0;
            case (state)
                SER_IDLE: begin
                    line <= 1'b1;
                    if (pop) begin
                        // Start bit goes out on the pop edge
                        line      <= 1'b0;
                        is_addr_q <= head.is_addr;
                        bit_cnt   <= head.is_addr ? LEN_BITS'(WIDTH) : eff_len;
                        state     <= SER_START;
                    end
                end
                SER_START: begin
                    line  <= is_addr_q ? TYPE_ADDR : TYPE_DATA;
                    state <= SER_TYPE;
                end
                SER_TYPE, SER_DATA: begin
                    if (bit_cnt == '0) begin
                        // Payload done, at least one idle cycle follows
                        line  <= 1'b1;
                        state <= SER_IDLE;
                    end else begin
                        line      <= shift_buf[WIDTH-1];
                        bit_cnt   <= bit_cnt - 1'b1;
                        data_sent <= (bit_cnt == LEN_BITS'(1));
                        state     <= SER_DATA;
                    end
                end
                default: begin
                    line  <= 1'b1;
                    state <= SER_IDLE;
                end
            endcase
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payload shifter
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_buf <= head.payload;
        end else if (state == SER_TYPE || state == SER_DATA) begin
            // Top bit is always the next one to send
            shift_buf <= {shift_buf[WIDTH-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* serial_parallel.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame deserializer
// Finds the start bit, reads the type bit and rebuilds the payload as a
// left-aligned, zero-filled word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module serial_parallel
    import serial_link_pkg::*;
#(
    parameter int WIDTH    = WORD_W,
    parameter int LEN_BITS = LEN_W
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  line,
    input  len_t  eff_len,
    output logic  rx_valid,
    output logic  rx_is_addr,
    output word_t rx_word
);

    des_state_t          state;
    logic                is_addr_q;
    logic                done;
    logic                type_is_addr;
    logic [LEN_BITS-1:0] bit_cnt;
    logic [LEN_BITS-1:0] bit_pos;
    logic [WIDTH-1:0]    word_buf;

    assign type_is_addr = (line == TYPE_ADDR);

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive FSM, each bit sampled at the edge that ends it
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= DES_IDLE;
            is_addr_q <= 1'b0;
            done      <= 1'b0;
            bit_cnt   <= '0;
            bit_pos   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            done     <= 1'b0;
            // Valid trails the last sample by one cycle
            rx_valid <= done;
            case (state)
                DES_IDLE: begin
                    if (!line) begin
                        state <= DES_TYPE;
                    end
                end
                DES_TYPE: begin
                    is_addr_q <= type_is_addr;
                    bit_cnt   <= type_is_addr ? LEN_BITS'(WIDTH) : eff_len;
                    bit_pos   <= LEN_BITS'(WIDTH - 1);
                    state     <= DES_DATA;
                end
                DES_DATA: begin
                    bit_pos <= bit_pos - 1'b1;
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == LEN_BITS'(1)) begin
                        done  <= 1'b1;
                        state <= DES_IDLE;
                    end
                end
                default: state <= DES_IDLE;
            endcase
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word assembly and output hold
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (state == DES_TYPE) begin
            // Bits below a short data frame stay zero
            word_buf <= '0;
        end else if (state == DES_DATA) begin
            word_buf[bit_pos] <= line;
        end
        if (done) begin
            rx_word    <= word_buf;
            rx_is_addr <= is_addr_q;
        end
    end

endmodule

`default_nettype wire

/* serial_link_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial link top level
// Transmit queue, serializer and deserializer with the line looped back
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module serial_link_top
    import serial_link_pkg::*;
#(
    parameter int WIDTH    = WORD_W,
    parameter int LEN_BITS = LEN_W,
    parameter int DEPTH    = 4
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       push,
    input  frame_req_t push_req,
    input  len_t       data_length,
    output logic       full,
    output logic       line,
    output logic       data_sent,
    output logic       rx_valid,
    output logic       rx_is_addr,
    output word_t      rx_word
);

    frame_req_t head;
    logic       empty;
    logic       pop;
    len_t       eff_len;

    // Port types are fixed by the package widths
    if (WIDTH != WORD_W || LEN_BITS != LEN_W) begin : g_param_check
        $error("serial_link_top parameters differ from serial_link_pkg widths");
    end

    // Zero length means a full word
    assign eff_len = (data_length == '0) ? LEN_BITS'(WIDTH) : data_length;

    tx_queue #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) u_tx_queue (
        .clk      (clk),
        .rstn     (rstn),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .full     (full)
    );

    parallel_serial #(
        .WIDTH    (WIDTH),
        .LEN_BITS (LEN_BITS)
    ) u_parallel_serial (
        .clk       (clk),
        .rstn      (rstn),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .eff_len   (eff_len),
        .line      (line),
        .data_sent (data_sent)
    );

    // Loopback, the receiver listens on the transmit line
    serial_parallel #(
        .WIDTH    (WIDTH),
        .LEN_BITS (LEN_BITS)
    ) u_serial_parallel (
        .clk        (clk),
        .rstn       (rstn),
        .line       (line),
        .eff_len    (eff_len),
        .rx_valid   (rx_valid),
        .rx_is_addr (rx_is_addr),
        .rx_word    (rx_word)
    );

endmodule

`default_nettype wire

/* serial_link_sva.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial link protocol assertions
// Idle line level, start bit and single-cycle status pulses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module serial_link_sva (
    input logic clk,
    input logic rstn,
    input logic pop,
    input logic line,
    input logic data_sent,
    input logic rx_valid
);

    // Frame in flight from the pop edge until the last payload bit ends
    logic busy;
    int   fail_count = 0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
        end else if (pop) begin
            busy <= 1'b1;
        end else if (data_sent) begin
            busy <= 1'b0;
        end
    end

    line_idle_high: assert property (@(posedge clk) disable iff (!rstn) !busy |-> line)
        else begin
            fail_count++;
            $error("line low while no frame is in progress");
        end

    start_bit_low: assert property (@(posedge clk) disable iff (!rstn) pop |=> !line)
        else begin
            fail_count++;
            $error("no start bit after pop");
        end

    idle_after_frame: assert property (@(posedge clk) disable iff (!rstn) data_sent |=> line)
        else begin
            fail_count++;
            $error("line not high after the last payload bit");
        end

    data_sent_pulse: assert property (@(posedge clk) disable iff (!rstn) data_sent |=> !data_sent)
        else begin
            fail_count++;
            $error("data_sent longer than one cycle");
        end

    rx_valid_pulse: assert property (@(posedge clk) disable iff (!rstn) rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx_valid longer than one cycle");
        end

endmodule

`default_nettype wire

/* serial_link_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial link testbench
// Pushes address and data frames through the looped-back link and checks
// every received word against a queue of expected frames
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module serial_link_tb
    import serial_link_pkg::*;
();

    localparam int WIDTH = WORD_W;
    localparam int DEPTH = 4;

    logic       clk;
    logic       rstn;
    logic       push;
    frame_req_t push_req;
    len_t       data_length;
    logic       full;
    logic       line;
    logic       data_sent;
    logic       rx_valid;
    logic       rx_is_addr;
    word_t      rx_word;

    // Expected frames in push order with payloads masked to their length
    frame_req_t  exp_q [$];
    logic [31:0] rng_state;
    string       test_name;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          accepted;
    int          dropped;
    int          rx_count   = 0;
    int          sent_count = 0;
    int          rx_errors  = 0;

    serial_link_top DUT (
        .clk         (clk),
        .rstn        (rstn),
        .push        (push),
        .push_req    (push_req),
        .data_length (data_length),
        .full        (full),
        .line        (line),
        .data_sent   (data_sent),
        .rx_valid    (rx_valid),
        .rx_is_addr  (rx_is_addr),
        .rx_word     (rx_word)
    );

    bind serial_link_top serial_link_sva u_sva (
        .clk       (clk),
        .rstn      (rstn),
        .pop       (pop),
        .line      (line),
        .data_sent (data_sent),
        .rx_valid  (rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t random_word();
        rng_state = xorshift32(rng_state);
        return rng_state[WIDTH-1:0];
    endfunction

    // Top N bits set where N is WIDTH for address frames and for length 0
    function automatic word_t frame_mask(input logic is_addr, input len_t len);
        word_t ones;
        int    n;
        ones = '1;
        n = (is_addr || len == '0) ? WIDTH : int'(len);
        return ~(ones >> n);
    endfunction

    // Outputs sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        frame_req_t exp;
        if (rstn && data_sent) begin
            sent_count++;
        end
        if (rstn && rx_valid) begin
            assert (rx_count < exp_q.size()) else begin
                $display("ERROR %s: frame received with none outstanding", test_name);
                rx_errors++;
            end
            if (rx_count < exp_q.size()) begin
                exp = exp_q[rx_count];
                assert (rx_is_addr == exp.is_addr && rx_word == exp.payload) else begin
                    $display("MISMATCH %s: expected addr=%0b word=%h, actual addr=%0b word=%h",
                             test_name, exp.is_addr, exp.payload, rx_is_addr, rx_word);
                    rx_errors++;
                end
            end
            rx_count++;
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors + rx_errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors + rx_errors == test_errors) begin
            $display("test %-14s ok", test_name);
        end else begin
            $display("test %-14s failed", test_name);
            tests_failed++;
        end
    endtask

    // A push while full is dropped by the queue and expects nothing
    task automatic push_frame(input logic is_addr, input word_t payload);
        frame_req_t exp;
        @(posedge clk);
        #1;
        push             = 1'b1;
        push_req.is_addr = is_addr;
        push_req.payload = payload;
        if (!full) begin
            exp.is_addr = is_addr;
            exp.payload = payload & frame_mask(is_addr, data_length);
            exp_q.push_back(exp);
            accepted++;
        end else begin
            dropped++;
        end
    endtask

    task automatic release_push();
        @(posedge clk);
        #1;
        push = 1'b0;
    endtask

    task automatic wait_rx(input int target);
        int cycles;
        int limit;
        cycles = 0;
        limit  = 40 * (target - rx_count) + 40;
        while (rx_count < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        assert (rx_count >= target) else begin
            $display("ERROR %s: timed out after %0d cycles waiting for frame %0d",
                     test_name, limit, target);
            errors++;
        end
        assert (sent_count == rx_count) else begin
            $display("ERROR %s: %0d data_sent pulses for %0d received frames",
                     test_name, sent_count, rx_count);
            errors++;
        end
    endtask

    task automatic after_reset();
        start_test("reset");
        assert (line === 1'b1 && full === 1'b0) else begin
            $display("ERROR %s: line not idle high or full set after reset", test_name);
            errors++;
        end
        assert (data_sent === 1'b0 && rx_valid === 1'b0) else begin
            $display("ERROR %s: output pulse active after reset", test_name);
            errors++;
        end
        repeat (20) @(posedge clk);
        assert (rx_count == 0) else begin
            $display("ERROR %s: frame received with nothing pushed", test_name);
            errors++;
        end
        finish_test();
    endtask

    task automatic addr_round_trip();
        start_test("addr_frame");
        push_frame(1'b1, random_word());
        release_push();
        wait_rx(accepted);
        finish_test();
    endtask

    task automatic data_length_sweep();
        int lens [4];
        lens = '{1, 7, WIDTH, 0};
        start_test("data_lengths");
        foreach (lens[i]) begin
            @(posedge clk);
            #1;
            data_length = len_t'(lens[i]);
            push_frame(1'b0, random_word());
            release_push();
            wait_rx(accepted);
        end
        finish_test();
    endtask

    // Back to back pushes overrun the queue while the first frame is sent
    task automatic burst_overflow();
        int i;
        start_test("burst");
        @(posedge clk);
        #1;
        data_length = len_t'(7);
        dropped     = 0;
        // Data and address frames alternate
        for (i = 0; i < DEPTH + 2; i++) begin
            push_frame(i[0], random_word());
        end
        release_push();
        assert (dropped > 0) else begin
            $display("ERROR %s: full never rose during the burst", test_name);
            errors++;
        end
        wait_rx(accepted);
        finish_test();
    endtask

    task automatic pulse_counts();
        start_test("pulse_counts");
        repeat (30) @(posedge clk);
        assert (sent_count == accepted && rx_count == accepted) else begin
            $display("ERROR %s: %0d pushes accepted, %0d data_sent, %0d rx_valid",
                     test_name, accepted, sent_count, rx_count);
            errors++;
        end
        finish_test();
    endtask

    initial begin
        int sva_fails;
        int total;
        rng_state    = 32'ha49d;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        accepted     = 0;
        dropped      = 0;
        test_name    = "init";
        rstn         = 1'b0;
        push         = 1'b0;
        push_req     = '0;
        data_length  = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        after_reset();
        addr_round_trip();
        data_length_sweep();
        burst_overflow();
        pulse_counts();

        sva_fails = DUT.u_sva.fail_count;
        total     = errors + rx_errors + sva_fails;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors + rx_errors, sva_fails);
        if (total == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
serial_link_pkg.sv
tx_queue.sv
parallel_serial.sv
serial_parallel.sv
serial_link_top.sv
serial_link_sva.sv
serial_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the serial link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module serial_link_tb -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vserial_link_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
